// ==== issue_top.f ====
design/core_types_pkg.sv
design/cdb_pkg.sv
design/reservation_station.sv
design/mul_unit.sv
design/alu_unit.sv
design/cdb_arbiter.sv
design/issue_top.sv
sim/issue_top_assertions.sv
sim/issue_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module issue_top_tb -f issue_top.f \
  -o issue_top_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/issue_top_sim > sim.log 2>&1
grep -qx "All checks passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== sim/issue_input.txt ====
# d unit(0 alu, 1 mul) op dst a_tag a_val a_rdy b_tag b_val b_rdy keep expected, all hex
# w tag value (rides on the next cycle), f flush, i cycles (0 random), c unit full
d 0 0 01 00 1234 1 00 0111 1 1 1345
d 1 0 05 01 0000 0 00 0003 1 1 39cf
d 0 1 02 00 1000 1 00 0001 1 1 0fff
d 0 2 03 00 f0f0 1 00 ff00 1 1 f000
d 0 3 04 00 aaaa 1 00 5555 1 1 ffff
w 10 0007
d 1 1 06 10 0000 0 00 9000 1 1 0003
d 1 1 07 00 ffff 1 00 ffff 1 1 fffe
d 0 0 09 07 0000 0 00 0002 1 1 0000
d 1 0 08 11 0000 0 00 0100 1 1 2300
i 0
w 11 0123
i 20
d 1 0 20 3e 0000 0 00 0001 1 0 0000
d 1 0 21 3e 0000 0 00 0001 1 0 0000
d 1 0 22 3e 0000 0 00 0001 1 0 0000
c 1 0
d 1 0 23 3e 0000 0 00 0001 1 0 0000
c 1 1
f
c 1 0
d 1 0 24 00 0004 1 00 0005 1 1 0014
d 0 1 25 24 0000 0 00 0004 1 1 0010
i 0

// ==== sim/issue_top_tb.sv ====
module issue_top_tb;
  import core_types_pkg::*;

  localparam string input_path = "sim/issue_input.txt";
  localparam int    tags       = 1 << $bits(tag_t);

  logic    clk;
  logic    arst_n;
  logic    flush;
  logic    alu_disp, alu_a_rdy, alu_b_rdy, alu_full;
  alu_op_t alu_op;
  tag_t    alu_dst, alu_a_tag, alu_b_tag;
  word_t   alu_a_val, alu_b_val;
  logic    mul_disp, mul_a_rdy, mul_b_rdy, mul_full;
  mul_op_t mul_op;
  tag_t    mul_dst, mul_a_tag, mul_b_tag;
  word_t   mul_a_val, mul_b_val;
  logic    ext_wake_valid;
  tag_t    ext_wake_tag;
  word_t   ext_wake_data;
  logic    cdb_valid;
  tag_t    cdb_tag;
  word_t   cdb_data;

  word_t   expected [tags];  // scoreboard indexed by destination tag
  bit      pending  [tags];
  int      outstanding = 0;
  int      cycles      = 0;
  int      limit       = 0;
  integer  seed        = 32'h5d5a_a80d;
  logic    wake_pend;
  tag_t    wake_tag_q;
  word_t   wake_data_q;

  issue_top #(.alu_depth(8), .mul_depth(4)) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ****************************************
  // checks
  // ****************************************

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_tag(input tag_t got);
    if (!pending[got])
      stop_with_failure($sformatf("result for tag %h at time %0t was not expected", got, $time));
  endtask

  task automatic check_word(input string name, input word_t want, input word_t got);
    if (got !== want)
      stop_with_failure($sformatf("FAILED at %0t: %s expected %h, got %h",
                                  $time, name, want, got));
  endtask

  task automatic check_level(input string name, input logic want, input logic got);
    if (got !== want)
      stop_with_failure($sformatf("FAILED at %0t: %s expected %b, got %b",
                                  $time, name, want, got));
  endtask

  // each tag is retired once, a repeat finds it no longer pending
  always @(negedge clk) begin
    if (arst_n && cdb_valid) begin
      check_tag(cdb_tag);
      check_word("cdb_data", expected[cdb_tag], cdb_data);
      pending[cdb_tag] = 1'b0;
      outstanding--;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit)
      stop_with_failure($sformatf("run went past its limit of %0d cycles", limit));
  end

  // ****************************************
  // stimulus
  // ****************************************

  task automatic next_cycle;
    @(negedge clk);
    alu_disp       = 1'b0;
    mul_disp       = 1'b0;
    flush          = 1'b0;
    ext_wake_valid = wake_pend;  // a queued wakeup rides on this cycle
    ext_wake_tag   = wake_tag_q;
    ext_wake_data  = wake_data_q;
    wake_pend      = 1'b0;
  endtask

  initial begin
    int               fd;
    int               rc;
    int               nlines;
    int               gap;
    int               missing;
    logic [7:0]       cmd;
    logic [8*100-1:0] text;
    logic             unit, a_rdy, b_rdy, keep, full_want;
    logic [1:0]       op;
    tag_t             dst, a_tag, b_tag;
    word_t            a_val, b_val, result;
    arst_n   = 1'b0;
    flush    = 1'b0;
    alu_disp = 1'b0;
    mul_disp = 1'b0;
    alu_op   = alu_add;
    mul_op   = mul_lo;
    {alu_dst, alu_a_tag, alu_a_val, alu_a_rdy, alu_b_tag, alu_b_val, alu_b_rdy} = '0;
    {mul_dst, mul_a_tag, mul_a_val, mul_a_rdy, mul_b_tag, mul_b_val, mul_b_rdy} = '0;
    ext_wake_valid = 1'b0;
    ext_wake_tag   = '0;
    ext_wake_data  = '0;
    wake_pend      = 1'b0;
    wake_tag_q     = '0;
    wake_data_q    = '0;
    nlines         = 0;
    missing        = 0;

    fd = $fopen(input_path, "r");
    if (fd == 0) stop_with_failure("cannot open the stimulus file");
    while (!$feof(fd)) begin
      rc = $fgets(text, fd);
      nlines++;
    end
    $fclose(fd);
    limit = 20 * nlines + 50;
    fd    = $fopen(input_path, "r");

    repeat (8) @(negedge clk);
    check_level("alu_full", 1'b0, alu_full);  // both stations come out of reset empty
    check_level("mul_full", 1'b0, mul_full);
    arst_n = 1'b1;

    while ($fscanf(fd, "%s", cmd) == 1) begin
      case (cmd)
        "#": rc = $fgets(text, fd);
        "d": begin
          rc = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h",
                       unit, op, dst, a_tag, a_val, a_rdy, b_tag, b_val, b_rdy, keep, result);
          if (rc != 11) stop_with_failure("a dispatch line in the stimulus file is incomplete");
          next_cycle();
          alu_op = alu_op_t'(op);
          mul_op = mul_op_t'(op[0]);
          {alu_dst, alu_a_tag, alu_a_val, alu_a_rdy} = {dst, a_tag, a_val, a_rdy};
          {alu_b_tag, alu_b_val, alu_b_rdy}          = {b_tag, b_val, b_rdy};
          {mul_dst, mul_a_tag, mul_a_val, mul_a_rdy} = {dst, a_tag, a_val, a_rdy};
          {mul_b_tag, mul_b_val, mul_b_rdy}          = {b_tag, b_val, b_rdy};
          if (unit) mul_disp = 1'b1;
          else alu_disp = 1'b1;
          if (keep) begin  // flushed entries never get a scoreboard slot
            expected[dst] = result;
            pending[dst]  = 1'b1;
            outstanding++;
          end
        end
        "w": begin
          rc        = $fscanf(fd, "%h %h", wake_tag_q, wake_data_q);
          wake_pend = 1'b1;
        end
        "f": begin
          next_cycle();
          flush = 1'b1;
        end
        "i": begin
          rc = $fscanf(fd, "%d", gap);
          if (gap == 0) gap = 1 + ($unsigned($random(seed)) % 8);
          repeat (gap) next_cycle();
        end
        "c": begin
          rc = $fscanf(fd, "%h %h", unit, full_want);
          next_cycle();
          if (unit) check_level("mul_full", full_want, mul_full);
          else check_level("alu_full", full_want, alu_full);
        end
        default: stop_with_failure("unknown command in the stimulus file");
      endcase
    end
    $fclose(fd);
    next_cycle();

    for (int k = 0; k < 60 && outstanding != 0; k++) begin
      @(negedge clk);
    end
    repeat (10) @(negedge clk);  // late duplicates or flushed tags would land here
    for (int t = 0; t < tags; t++) begin
      if (pending[t]) begin
        $display("tag %h never appeared on the result bus", t[5:0]);
        missing++;
      end
    end
    if (missing == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1, "%0d results missing", missing);
    end
  end

endmodule

// ==== sim/issue_top_assertions.sv ====
module issue_top_assertions (
  input logic                            clk,
  input logic                            arst_n,
  input logic [cdb_pkg::CDB_SOURCES-1:0] req,
  input logic [cdb_pkg::CDB_SOURCES-1:0] grant,
  input logic                            alu_disp,
  input logic                            alu_full,
  input logic                            mul_disp,
  input logic                            mul_full,
  input logic                            cdb_valid
);
  import cdb_pkg::*;

  localparam cdb_src_t alu_src = cdb_src_t'(0);
  localparam cdb_src_t mul_src = cdb_src_t'(1);

  // ****************************************
  // result bus
  // ****************************************

  grant_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(grant))
    else $error("more than one bus grant in a cycle");

  // a unit that loses the bus keeps its result up
  alu_req_held: assert property (@(posedge clk) disable iff (!arst_n)
    req[alu_src] && !grant[alu_src] |=> req[alu_src])
    else $error("alu dropped a result that was never granted");
  mul_req_held: assert property (@(posedge clk) disable iff (!arst_n)
    req[mul_src] && !grant[mul_src] |=> req[mul_src])
    else $error("multiplier dropped a result that was never granted");

  cdb_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !cdb_valid)
    else $error("cdb_valid high during reset");

  // ****************************************
  // dispatch
  // ****************************************

  alu_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    alu_disp |-> !alu_full)
    else $error("dispatch into a full alu station");
  mul_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    mul_disp |-> !mul_full)
    else $error("dispatch into a full multiplier station");

endmodule

bind issue_top issue_top_assertions u_assertions (
  .clk(clk), .arst_n(arst_n), .req(req), .grant(grant),
  .alu_disp(alu_disp), .alu_full(alu_full),
  .mul_disp(mul_disp), .mul_full(mul_full),
  .cdb_valid(cdb_valid)
);

// ==== design/issue_top.sv ====
module issue_top #(
  parameter int alu_depth = core_types_pkg::RS_DEPTH_DEFAULT,
  parameter int mul_depth = core_types_pkg::RS_DEPTH_DEFAULT
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    flush,
  input  logic                    alu_disp,
  input  core_types_pkg::alu_op_t alu_op,
  input  core_types_pkg::tag_t    alu_dst,
  input  core_types_pkg::tag_t    alu_a_tag,
  input  core_types_pkg::word_t   alu_a_val,
  input  logic                    alu_a_rdy,
  input  core_types_pkg::tag_t    alu_b_tag,
  input  core_types_pkg::word_t   alu_b_val,
  input  logic                    alu_b_rdy,
  output logic                    alu_full,
  input  logic                    mul_disp,
  input  core_types_pkg::mul_op_t mul_op,
  input  core_types_pkg::tag_t    mul_dst,
  input  core_types_pkg::tag_t    mul_a_tag,
  input  core_types_pkg::word_t   mul_a_val,
  input  logic                    mul_a_rdy,
  input  core_types_pkg::tag_t    mul_b_tag,
  input  core_types_pkg::word_t   mul_b_val,
  input  logic                    mul_b_rdy,
  output logic                    mul_full,
  input  logic                    ext_wake_valid,
  input  core_types_pkg::tag_t    ext_wake_tag,
  input  core_types_pkg::word_t   ext_wake_data,
  output logic                    cdb_valid,
  output core_types_pkg::tag_t    cdb_tag,
  output core_types_pkg::word_t   cdb_data
);
  import core_types_pkg::*;
  import cdb_pkg::*;

  logic    alu_issue, alu_busy;
  alu_op_t alu_issue_op;
  tag_t    alu_issue_tag;
  word_t   alu_issue_a, alu_issue_b;
  logic    mul_issue, mul_busy;
  mul_op_t mul_issue_op;
  tag_t    mul_issue_tag;
  word_t   mul_issue_a, mul_issue_b;

  // bus requester 0 is the alu, 1 the multiplier
  wire [CDB_SOURCES-1:0] req;
  wire [CDB_SOURCES-1:0] grant;
  wire tag_t             res_tag  [CDB_SOURCES];
  wire word_t            res_data [CDB_SOURCES];

  reservation_station #(.depth(alu_depth), .op_t(alu_op_t)) u_alu_rs (
    .clk(clk), .arst_n(arst_n), .flush(flush),
    .disp(alu_disp), .disp_op(alu_op), .disp_tag(alu_dst),
    .disp_a_tag(alu_a_tag), .disp_b_tag(alu_b_tag),
    .disp_a_val(alu_a_val), .disp_b_val(alu_b_val),
    .disp_a_rdy(alu_a_rdy), .disp_b_rdy(alu_b_rdy),
    .wake_valid(cdb_valid), .ext_valid(ext_wake_valid),
    .wake_tag(cdb_tag), .ext_tag(ext_wake_tag),
    .wake_data(cdb_data), .ext_data(ext_wake_data),
    .unit_busy(alu_busy), .full(alu_full),
    .issue(alu_issue), .issue_op(alu_issue_op), .issue_tag(alu_issue_tag),
    .issue_a(alu_issue_a), .issue_b(alu_issue_b)
  );

  reservation_station #(.depth(mul_depth), .op_t(mul_op_t)) u_mul_rs (
    .clk(clk), .arst_n(arst_n), .flush(flush),
    .disp(mul_disp), .disp_op(mul_op), .disp_tag(mul_dst),
    .disp_a_tag(mul_a_tag), .disp_b_tag(mul_b_tag),
    .disp_a_val(mul_a_val), .disp_b_val(mul_b_val),
    .disp_a_rdy(mul_a_rdy), .disp_b_rdy(mul_b_rdy),
    .wake_valid(cdb_valid), .ext_valid(ext_wake_valid),
    .wake_tag(cdb_tag), .ext_tag(ext_wake_tag),
    .wake_data(cdb_data), .ext_data(ext_wake_data),
    .unit_busy(mul_busy), .full(mul_full),
    .issue(mul_issue), .issue_op(mul_issue_op), .issue_tag(mul_issue_tag),
    .issue_a(mul_issue_a), .issue_b(mul_issue_b)
  );

  alu_unit u_alu (
    .clk(clk), .arst_n(arst_n),
    .issue(alu_issue), .op(alu_issue_op), .tag(alu_issue_tag),
    .a(alu_issue_a), .b(alu_issue_b), .grant(grant[0]),
    .req(req[0]), .res_tag(res_tag[0]), .res_data(res_data[0]), .busy(alu_busy)
  );

  mul_unit u_mul (
    .clk(clk), .arst_n(arst_n),
    .issue(mul_issue), .op(mul_issue_op), .tag(mul_issue_tag),
    .a(mul_issue_a), .b(mul_issue_b), .grant(grant[1]),
    .req(req[1]), .res_tag(res_tag[1]), .res_data(res_data[1]), .busy(mul_busy)
  );

  cdb_arbiter u_arb (
    .clk(clk), .arst_n(arst_n),
    .req(req), .res_tag(res_tag), .res_data(res_data), .grant(grant),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data)
  );

endmodule

// ==== design/cdb_arbiter.sv ====
module cdb_arbiter (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic [cdb_pkg::CDB_SOURCES-1:0]    req,
  input  core_types_pkg::tag_t               res_tag  [cdb_pkg::CDB_SOURCES],
  input  core_types_pkg::word_t              res_data [cdb_pkg::CDB_SOURCES],
  output logic [cdb_pkg::CDB_SOURCES-1:0]    grant,
  output logic                               cdb_valid,
  output core_types_pkg::tag_t               cdb_tag,
  output core_types_pkg::word_t              cdb_data
);
  import cdb_pkg::*;

  cdb_src_t ptr_q;  // first requester looked at this cycle
  cdb_src_t win;
  logic     found;

  always_comb begin
    cdb_src_t idx;
    grant = '0;
    win   = ptr_q;
    found = 1'b0;
    for (int k = 0; k < CDB_SOURCES; k++) begin
      idx = cdb_src_t'((int'(ptr_q) + k) % CDB_SOURCES);
      if (!found && req[idx]) begin
        found = 1'b1;
        win   = idx;
      end
    end
    if (found) grant[win] = 1'b1;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr_q     <= '0;
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= found;
      if (found) ptr_q <= cdb_src_t'((int'(win) + 1) % CDB_SOURCES);  // past the winner
    end
  end

  always_ff @(posedge clk) begin
    if (found) begin
      cdb_tag  <= res_tag[win];
      cdb_data <= res_data[win];
    end
  end

endmodule

// ==== design/alu_unit.sv ====
module alu_unit (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    issue,
  input  core_types_pkg::alu_op_t op,
  input  core_types_pkg::tag_t    tag,
  input  core_types_pkg::word_t   a,
  input  core_types_pkg::word_t   b,
  input  logic                    grant,
  output logic                    req,
  output core_types_pkg::tag_t    res_tag,
  output core_types_pkg::word_t   res_data,
  output logic                    busy
);
  import core_types_pkg::*;

  word_t result;
  logic  slot_valid;
  tag_t  slot_tag;
  word_t slot_data;

  always_comb begin
    case (op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_xor: result = a ^ b;
    endcase
  end

  // the slot may refill in the same cycle it is granted
  assign busy = slot_valid && !grant;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) slot_valid <= 1'b0;
    else if (issue) slot_valid <= 1'b1;
    else if (grant) slot_valid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      slot_tag  <= tag;
      slot_data <= result;
    end
  end

  assign req      = slot_valid;
  assign res_tag  = slot_tag;
  assign res_data = slot_data;

endmodule

// ==== design/mul_unit.sv ====
module mul_unit (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    issue,
  input  core_types_pkg::mul_op_t op,
  input  core_types_pkg::tag_t    tag,
  input  core_types_pkg::word_t   a,
  input  core_types_pkg::word_t   b,
  input  logic                    grant,
  output logic                    req,
  output core_types_pkg::tag_t    res_tag,
  output core_types_pkg::word_t   res_data,
  output logic                    busy
);
  import core_types_pkg::*;

  logic        s1_valid;
  mul_op_t     s1_op;
  tag_t        s1_tag;
  word_t       s1_a;
  word_t       s1_b;
  logic [31:0] product;
  logic        slot_valid;
  tag_t        slot_tag;
  word_t       slot_data;
  logic        advance;

  assign product = 32'(s1_a) * 32'(s1_b);
  assign advance = s1_valid && (!slot_valid || grant);  // slot free or leaving now
  assign busy    = s1_valid && !advance;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid   <= 1'b0;
      slot_valid <= 1'b0;
    end else begin
      if (issue) s1_valid <= 1'b1;
      else if (advance) s1_valid <= 1'b0;
      if (advance) slot_valid <= 1'b1;
      else if (grant) slot_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      s1_op  <= op;
      s1_tag <= tag;
      s1_a   <= a;
      s1_b   <= b;
    end
    if (advance) begin
      slot_tag  <= s1_tag;
      slot_data <= (s1_op == mul_hi) ? product[31:16] : product[15:0];
    end
  end

  assign req      = slot_valid;
  assign res_tag  = slot_tag;
  assign res_data = slot_data;

endmodule

// ==== design/reservation_station.sv ====
module reservation_station #(
  parameter int  depth = core_types_pkg::RS_DEPTH_DEFAULT,
  parameter type op_t  = core_types_pkg::alu_op_t
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  flush,
  input  logic                  disp,
  input  op_t                   disp_op,
  input  core_types_pkg::tag_t  disp_tag,
  input  core_types_pkg::tag_t  disp_a_tag,
  input  core_types_pkg::tag_t  disp_b_tag,
  input  core_types_pkg::word_t disp_a_val,
  input  core_types_pkg::word_t disp_b_val,
  input  logic                  disp_a_rdy,
  input  logic                  disp_b_rdy,
  input  logic                  wake_valid,
  input  logic                  ext_valid,
  input  core_types_pkg::tag_t  wake_tag,
  input  core_types_pkg::tag_t  ext_tag,
  input  core_types_pkg::word_t wake_data,
  input  core_types_pkg::word_t ext_data,
  input  logic                  unit_busy,
  output logic                  full,
  output logic                  issue,
  output op_t                   issue_op,
  output core_types_pkg::tag_t  issue_tag,
  output core_types_pkg::word_t issue_a,
  output core_types_pkg::word_t issue_b
);
  import core_types_pkg::*;

  localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;

  logic [depth-1:0] valid_q;
  logic [depth-1:0] a_rdy_q;
  logic [depth-1:0] b_rdy_q;
  op_t              op_q    [depth];
  tag_t             dst_q   [depth];
  tag_t             a_tag_q [depth];
  tag_t             b_tag_q [depth];
  word_t            a_val_q [depth];
  word_t            b_val_q [depth];

  logic [depth-1:0] ready_vec;
  logic             sel_found;
  logic [idx_w-1:0] sel_idx;
  logic [idx_w-1:0] free_idx;
  logic             do_alloc;
  logic             a_rdy_in;
  logic             b_rdy_in;
  word_t            a_val_in;
  word_t            b_val_in;

  // a tag is woken by either the result bus or the external producers
  function automatic logic snoop_hit(input tag_t t);
    return (wake_valid && wake_tag == t) || (ext_valid && ext_tag == t);
  endfunction

  function automatic word_t snoop_data(input tag_t t);
    return (wake_valid && wake_tag == t) ? wake_data : ext_data;
  endfunction

  assign ready_vec = valid_q & a_rdy_q & b_rdy_q;
  assign full      = &valid_q;
  assign do_alloc  = disp && !full;  // a dispatch into a full station is lost

  // ****************************************
  // issue select and allocation
  // ****************************************

  // walking down leaves the lowest matching index behind
  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    free_idx  = '0;
    for (int i = depth - 1; i >= 0; i--) begin
      if (ready_vec[i]) begin
        sel_found = 1'b1;
        sel_idx   = idx_w'(i);
      end
      if (!valid_q[i]) begin
        free_idx = idx_w'(i);
      end
    end
  end

  assign issue     = sel_found && !unit_busy;
  assign issue_op  = op_q[sel_idx];
  assign issue_tag = dst_q[sel_idx];
  assign issue_a   = a_val_q[sel_idx];
  assign issue_b   = b_val_q[sel_idx];

  // dispatch bypass, a source not ready yet may still be on a bus this cycle
  always_comb begin
    a_rdy_in = disp_a_rdy || snoop_hit(disp_a_tag);
    b_rdy_in = disp_b_rdy || snoop_hit(disp_b_tag);
    a_val_in = disp_a_rdy ? disp_a_val : snoop_data(disp_a_tag);
    b_val_in = disp_b_rdy ? disp_b_val : snoop_data(disp_b_tag);
  end

  // ****************************************
  // entry state
  // ****************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (flush) begin
      valid_q <= '0;
    end else begin
      if (issue) valid_q[sel_idx] <= 1'b0;
      if (do_alloc) valid_q[free_idx] <= 1'b1;  // never the issuing entry
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < depth; i++) begin
      if (valid_q[i] && !a_rdy_q[i] && snoop_hit(a_tag_q[i])) begin
        a_rdy_q[i] <= 1'b1;
        a_val_q[i] <= snoop_data(a_tag_q[i]);
      end
      if (valid_q[i] && !b_rdy_q[i] && snoop_hit(b_tag_q[i])) begin
        b_rdy_q[i] <= 1'b1;
        b_val_q[i] <= snoop_data(b_tag_q[i]);
      end
    end
    if (do_alloc) begin
      op_q[free_idx]    <= disp_op;
      dst_q[free_idx]   <= disp_tag;
      a_tag_q[free_idx] <= disp_a_tag;
      b_tag_q[free_idx] <= disp_b_tag;
      a_rdy_q[free_idx] <= a_rdy_in;
      b_rdy_q[free_idx] <= b_rdy_in;
      a_val_q[free_idx] <= a_val_in;
      b_val_q[free_idx] <= b_val_in;
    end
  end

endmodule

// ==== design/cdb_pkg.sv ====
package cdb_pkg;

  // requesters sharing the common result bus
  localparam int CDB_SOURCES = 2;

  // index 0 is the alu and index 1 the multiplier
  typedef logic [$clog2(CDB_SOURCES)-1:0] cdb_src_t;

endpackage

// ==== design/core_types_pkg.sv ====
package core_types_pkg;

  // ****************************************
  // operand and tag widths
  // ****************************************

  typedef logic [5:0]  tag_t;   // physical register tag
  typedef logic [15:0] word_t;  // data word carried on every bus

  // ****************************************
  // opcodes per execution unit
  // ****************************************

  // low or high half of the unsigned 16x16 product
  typedef enum logic {
    mul_lo,
    mul_hi
  } mul_op_t;

  typedef enum logic [1:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_xor
  } alu_op_t;

  localparam int RS_DEPTH_DEFAULT = 8;

endpackage
